// ==== coreDefs.sv ====
package coreDefs;

	// datapath sizes
	localparam int dataWidth  = 16;                // one machine word
	localparam int regCount   = 16;                // r0 to r15
	localparam int addrWidth  = 4;                 // picks one of regCount
	localparam int opWidth    = 4;                 // opcode field
	localparam int immWidth   = 8;                 // immediate field, signed
	localparam int aluOpWidth = 3;                 // alu function select
	localparam int shiftWidth = $clog2(dataWidth); // shift amount is b mod 16

	// opcodes in the top nibble of every instruction
	typedef enum logic [opWidth-1:0] {
		ADD  = 4'h0, // dst = dst + src
		SUB  = 4'h1, // dst = dst - src
		AND  = 4'h2,
		OR   = 4'h3,
		XOR  = 4'h4,
		SHL  = 4'h5, // shift left by src mod 16
		SHR  = 4'h6, // logical shift right
		MOV  = 4'h7, // dst = src
		ADDI = 4'h8, // dst = dst + sext(imm)
		LDI  = 4'h9, // dst = sext(imm), flags untouched
		CMP  = 4'hA, // dst - src, flags only
		// 4'hB to 4'hE are free and decode like NOP
		NOP  = 4'hF
	} opcode_e;

	// functions the alu knows about
	typedef enum logic [aluOpWidth-1:0] {
		ALU_ADD   = 3'd0,
		ALU_SUB   = 3'd1, // carry out is "no borrow"
		ALU_AND   = 3'd2,
		ALU_OR    = 3'd3,
		ALU_XOR   = 3'd4,
		ALU_SHL   = 3'd5,
		ALU_SHR   = 3'd6,
		ALU_PASSB = 3'd7  // operand b straight through
	} aluOp_e;

	// register form
	// opcode | dst | src | unused
	typedef struct packed {
		opcode_e                opcode;
		logic [addrWidth-1:0]   dst;    // also the first source
		logic [addrWidth-1:0]   src;
		logic [addrWidth-1:0]   unused; // ignored by the decoder
	} instrReg_t;

	// immediate form
	// opcode | dst | imm
	typedef struct packed {
		opcode_e                opcode;
		logic [addrWidth-1:0]   dst;
		logic [immWidth-1:0]    imm;    // two's complement
	} instrImm_t;

	// the same 16-bit word seen both ways
	// opcode and dst sit in the same bits in either view
	typedef union packed {
		instrReg_t regView;
		instrImm_t immView;
	} instr_u;

endpackage

// ==== registerFile.sv ====
// 16 x 16 register file
// one write port addressed by dstAddr, two combinational read ports
module registerFile import coreDefs::*; (
	input  logic                 clk,
	input  logic                 rst,        // sync, clears every register
	input  logic                 writeEn,
	input  logic [addrWidth-1:0] dstAddr,    // write address and read port 1
	input  logic [addrWidth-1:0] srcAddr,    // read port 2
	input  logic [dataWidth-1:0] writeData,
	output logic [dataWidth-1:0] readData1,  // regs[dstAddr]
	output logic [dataWidth-1:0] readData2   // regs[srcAddr]
);

	// storage
	logic [dataWidth-1:0] regs [regCount];

	// write port
	// the whole array clears on rst so the core starts from a known state
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn) begin
			regs[dstAddr] <= writeData; // visible on the read ports next cycle
		end
	end

	// read ports
	// no bypass, a write lands at the edge and the array is read after it
	assign readData1 = regs[dstAddr]; // first operand of a two-address op
	assign readData2 = regs[srcAddr]; // second operand

	// a write with an unknown address would corrupt some unknown register,
	// and an unknown srcAddr means the result being written is garbage too
	assert property (@(posedge clk) disable iff (rst)
		writeEn |-> !$isunknown({dstAddr, srcAddr}))
	else $error("registerFile: unknown address during write");

endmodule

// ==== instrDecoder.sv ====
// instruction decoder
// opcode first, then the fields through the view the opcode selects
module instrDecoder import coreDefs::*; (
	input  instr_u               instr,
	output logic [addrWidth-1:0] dstAddr,    // same bits in both forms
	output logic [addrWidth-1:0] srcAddr,    // register form only
	output aluOp_e               aluOp,
	output logic                 useImm,     // operand b from immValue
	output logic [dataWidth-1:0] immValue,   // imm sign extended
	output logic                 writesBack, // result goes to dst
	output logic                 setsFlags   // zero, neg, carry load
);

	opcode_e opcode;

	// opcode lives in the shared top nibble, either view would do
	assign opcode = instr.regView.opcode;

	// field extraction
	assign dstAddr  = instr.regView.dst;
	assign srcAddr  = instr.regView.src; // meaningless for the immediate form
	assign immValue = {{(dataWidth-immWidth){instr.immView.imm[immWidth-1]}},
		instr.immView.imm};

	// control
	always_comb begin
		// most ops write back and set flags from operand b = src
		aluOp      = ALU_PASSB;
		useImm     = 1'b0;
		writesBack = 1'b1;
		setsFlags  = 1'b1;
		case (opcode)
			ADD: aluOp = ALU_ADD;
			SUB: aluOp = ALU_SUB;
			AND: aluOp = ALU_AND;
			OR:  aluOp = ALU_OR;
			XOR: aluOp = ALU_XOR;
			SHL: aluOp = ALU_SHL;
			SHR: aluOp = ALU_SHR;
			MOV: aluOp = ALU_PASSB; // alu clears carry for pass
			ADDI: begin
				aluOp  = ALU_ADD;
				useImm = 1'b1;
			end
			LDI: begin
				aluOp     = ALU_PASSB;
				useImm    = 1'b1;
				setsFlags = 1'b0; // load leaves flags alone
			end
			CMP: begin
				aluOp      = ALU_SUB;
				writesBack = 1'b0; // subtract for the flags only
			end
			default: begin
				// NOP and the free opcodes
				writesBack = 1'b0;
				setsFlags  = 1'b0;
			end
		endcase
	end

endmodule

// ==== alu.sv ====
// 16-bit alu
// result plus the next zero, negative and carry values
module alu import coreDefs::*; (
	input  logic [dataWidth-1:0] a,         // readData1, the dst register
	input  logic [dataWidth-1:0] b,         // src register or immediate
	input  aluOp_e               aluOp,
	output logic [dataWidth-1:0] aluResult,
	output logic                 zeroNext,
	output logic                 negNext,
	output logic                 carryNext
);

	logic [shiftWidth-1:0] shamt; // b mod 16
	logic [dataWidth:0]    sum;   // carry in the top bit
	logic [dataWidth:0]    diff;  // top bit set means no borrow
	logic [dataWidth:0]    shl;   // last bit out lands in bit 16
	logic [dataWidth:0]    shr;   // last bit out lands in bit 0

	assign shamt = b[shiftWidth-1:0];

	// adder and subtractor, 17 bits wide for the carry
	assign sum  = {1'b0, a} + {1'b0, b};
	assign diff = {1'b0, a} + {1'b0, ~b} + 1'b1; // a + ~b + 1

	// shifters
	// an extra bit on the outgoing side keeps the last bit shifted out,
	// and a shift by 0 leaves that bit at 0
	assign shl = {1'b0, a} << shamt;
	assign shr = {a, 1'b0} >> shamt;

	always_comb begin
		carryNext = 1'b0; // logic and pass ops clear carry
		case (aluOp)
			ALU_ADD: begin
				aluResult = sum[dataWidth-1:0];
				carryNext = sum[dataWidth];
			end
			ALU_SUB: begin
				aluResult = diff[dataWidth-1:0];
				carryNext = diff[dataWidth]; // 1 when a >= b unsigned
			end
			ALU_AND: aluResult = a & b;
			ALU_OR:  aluResult = a | b;
			ALU_XOR: aluResult = a ^ b;
			ALU_SHL: begin
				aluResult = shl[dataWidth-1:0];
				carryNext = shl[dataWidth];
			end
			ALU_SHR: begin
				aluResult = shr[dataWidth:1];
				carryNext = shr[0];
			end
			default: aluResult = b; // ALU_PASSB for MOV and LDI
		endcase
	end

	// status from the result word
	assign zeroNext = (aluResult == '0);
	assign negNext  = aluResult[dataWidth-1]; // sign bit

endmodule

// ==== execCore.sv ====
// single cycle execute core
// decode, read, alu and write back all inside one clock
module execCore import coreDefs::*; (
	input  logic                 clk,
	input  logic                 rst,        // sync, active high
	input  logic [dataWidth-1:0] instr,      // one instruction per strobe
	input  logic                 instrValid, // commit at this rising edge
	output logic [dataWidth-1:0] result,     // alu output, combinational
	output logic                 flagZero,
	output logic                 flagNeg,
	output logic                 flagCarry
);

	// decoder outputs
	logic [addrWidth-1:0] dstAddr;
	logic [addrWidth-1:0] srcAddr;
	aluOp_e               aluOp;
	logic                 useImm;
	logic [dataWidth-1:0] immValue;
	logic                 writesBack;
	logic                 setsFlags;

	// datapath
	logic [dataWidth-1:0] readData1; // dst register, operand a
	logic [dataWidth-1:0] readData2; // src register
	logic [dataWidth-1:0] operandB;
	logic [dataWidth-1:0] aluResult;
	logic                 zeroNext;
	logic                 negNext;
	logic                 carryNext;
	logic                 writeEn;

	instrDecoder decoder (
		.instr      (instr),       // same 16 bits, read through the union
		.dstAddr    (dstAddr),
		.srcAddr    (srcAddr),
		.aluOp      (aluOp),
		.useImm     (useImm),
		.immValue   (immValue),
		.writesBack (writesBack),
		.setsFlags  (setsFlags)
	);

	// instrValid is ignored while in reset
	assign writeEn = instrValid & writesBack & ~rst;

	registerFile regFile (
		.clk       (clk),
		.rst       (rst),
		.writeEn   (writeEn),
		.dstAddr   (dstAddr),
		.srcAddr   (srcAddr),
		.writeData (aluResult), // result written back at the same edge
		.readData1 (readData1),
		.readData2 (readData2)
	);

	// operand b select
	assign operandB = useImm ? immValue : readData2;

	alu execAlu (
		.a         (readData1),
		.b         (operandB),
		.aluOp     (aluOp),
		.aluResult (aluResult),
		.zeroNext  (zeroNext),
		.negNext   (negNext),
		.carryNext (carryNext)
	);

	assign result = aluResult;

	// flags
	// loaded only by committed instructions that set them,
	// NOP and LDI keep the old values
	always_ff @(posedge clk) begin
		if (rst) begin
			flagZero  <= 1'b0;
			flagNeg   <= 1'b0;
			flagCarry <= 1'b0;
		end else if (instrValid && setsFlags) begin
			flagZero  <= zeroNext;
			flagNeg   <= negNext;
			flagCarry <= carryNext;
		end
	end

	// the first cycle after any reset cycle starts with clean status
	assert property (@(posedge clk)
		rst |=> ({flagZero, flagNeg, flagCarry} == 3'b000))
	else $error("execCore: flags not clear after reset");

endmodule

// ==== execCore_tb.sv ====
module execCore_tb import coreDefs::*; ();

	localparam int clkPeriod   = 40;
	localparam int resetCycles = 16;
	localparam int randSeed    = 1875;
	localparam int numArith    = 200; // random ADD SUB ADDI CMP
	localparam int numLogic    = 200; // random AND OR XOR SHL SHR, some LDI refresh
	localparam int numGated    = 60;  // write instructions with instrValid low
	localparam int numNop      = 20;  // NOP with instrValid high
	localparam int numChain    = 60;  // dependent, back to back

	// every cycle the stimulus spends after reset, idle ones included
	localparam int totalInstr = 1 + regCount + 4*regCount + 6 + numArith + regCount
		+ numLogic + numGated + numNop + regCount + 1 + numChain + 2;
	localparam int watchdogTime = (totalInstr + resetCycles + 50) * clkPeriod;

	logic                 clk;
	logic                 rst;
	logic [dataWidth-1:0] instr;
	logic                 instrValid;
	logic [dataWidth-1:0] result;
	logic                 flagZero;
	logic                 flagNeg;
	logic                 flagCarry;

	// reference state, only the compare process writes it
	logic [dataWidth-1:0] modelRegs [regCount];
	logic                 modelZero;
	logic                 modelNeg;
	logic                 modelCarry;
	int                   committed; // instructions the model has retired

	execCore UUT (
		.clk        (clk),
		.rst        (rst),
		.instr      (instr),
		.instrValid (instrValid),
		.result     (result),
		.flagZero   (flagZero),
		.flagNeg    (flagNeg),
		.flagCarry  (flagCarry)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod/2) clk = ~clk;
	end

	// instruction builders
	function automatic instr_u encodeReg(input opcode_e op,
		input logic [addrWidth-1:0] dst, input logic [addrWidth-1:0] src);
		instr_u w;
		w.regView.opcode = op;
		w.regView.dst    = dst;
		w.regView.src    = src;
		w.regView.unused = '0;
		return w;
	endfunction

	function automatic instr_u encodeImm(input opcode_e op,
		input logic [addrWidth-1:0] dst, input logic [immWidth-1:0] imm);
		instr_u w;
		w.immView.opcode = op;
		w.immView.dst    = dst;
		w.immView.imm    = imm;
		return w;
	endfunction

	function automatic logic [addrWidth-1:0] randReg();
		logic [31:0] r;
		r = $urandom();
		return r[addrWidth-1:0];
	endfunction

	function automatic logic [immWidth-1:0] randImm();
		logic [31:0] r;
		r = $urandom();
		return r[immWidth-1:0];
	endfunction

	// expected result and flags after one instruction, from the opcode rules
	// hasResult is low where no result value is defined (NOP, free opcodes)
	function automatic void predictResult(
		input  logic [dataWidth-1:0] word,
		input  logic [dataWidth-1:0] regs [regCount],
		input  logic                 zIn,
		input  logic                 nIn,
		input  logic                 cIn,
		output logic [dataWidth-1:0] res,
		output logic                 zOut,
		output logic                 nOut,
		output logic                 cOut,
		output logic                 writes,
		output logic                 hasResult);
		logic [opWidth-1:0]    op;
		logic [dataWidth-1:0]  x;      // dst register
		logic [dataWidth-1:0]  y;      // src register
		logic [dataWidth-1:0]  sx;     // immediate, sign extended
		logic [shiftWidth-1:0] amt;
		logic [31:0]           wide;
		logic                  carry;
		logic                  flagsChange;
		op    = word[15:12];
		x     = regs[word[11:8]];
		y     = regs[word[7:4]];
		sx    = {{(dataWidth-immWidth){word[immWidth-1]}}, word[immWidth-1:0]};
		amt   = y[shiftWidth-1:0]; // shift count mod 16
		res   = '0;
		carry = 1'b0;
		writes      = 1'b1;
		flagsChange = 1'b1;
		hasResult   = 1'b1;
		case (op)
			ADD, ADDI: begin
				wide  = 32'(x) + ((op == ADDI) ? 32'(sx) : 32'(y));
				res   = wide[dataWidth-1:0];
				carry = (wide > 32'hFFFF); // out of 16 bits
			end
			SUB, CMP: begin
				res    = x - y;
				carry  = (x >= y);  // no borrow
				writes = (op == SUB);
			end
			AND: res = x & y;
			OR:  res = x | y;
			XOR: res = x ^ y;
			SHL: begin
				res = x;
				for (int k = 0; k < amt; k++) begin
					carry = res[dataWidth-1]; // bit leaving on the left
					res   = res << 1;
				end
			end
			SHR: begin
				res = x;
				for (int k = 0; k < amt; k++) begin
					carry = res[0];
					res   = res >> 1;
				end
			end
			MOV: res = y;
			LDI: begin
				res         = sx;
				flagsChange = 1'b0;
			end
			default: begin
				writes      = 1'b0;
				flagsChange = 1'b0;
				hasResult   = 1'b0;
			end
		endcase
		if (flagsChange) begin
			zOut = (res == '0);
			nOut = res[dataWidth-1];
			cOut = carry;
		end else begin
			zOut = zIn; // LDI and NOP keep the status
			nOut = nIn;
			cOut = cIn;
		end
	endfunction

	task automatic checkWord(input logic [dataWidth-1:0] got,
		input logic [dataWidth-1:0] expected, input string what);
		if (got !== expected) begin
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, expected);
			$display("Simulation FAILED");
			$fatal(1, "data word mismatch");
		end
	endtask

	task automatic checkFlags(input logic gotZ, input logic gotN, input logic gotC,
		input logic expZ, input logic expN, input logic expC, input string what);
		if ({gotZ, gotN, gotC} !== {expZ, expN, expC}) begin
			$display("CHECK FAILED at %0t: %s are z%b n%b c%b, expected z%b n%b c%b",
				$time, what, gotZ, gotN, gotC, expZ, expN, expC);
			$display("Simulation FAILED");
			$fatal(1, "flag mismatch");
		end
	endtask

	// one instruction per falling edge
	task automatic issue(input instr_u word, input logic valid);
		@(negedge clk);
		instr      = word;
		instrValid = valid;
	endtask

	// MOV rX,rX shows every register on result
	task automatic movSweep();
		for (int x = 0; x < regCount; x++) begin
			issue(encodeReg(MOV, addrWidth'(x), addrWidth'(x)), 1'b1);
		end
	endtask

	// compare, then retire into the model
	initial begin : compareProc
		logic [dataWidth-1:0] expRes;
		logic                 expZ;
		logic                 expN;
		logic                 expC;
		logic                 writes;
		logic                 hasResult;
		for (int i = 0; i < regCount; i++) begin
			modelRegs[i] = '0; // reset value
		end
		modelZero  = 1'b0;
		modelNeg   = 1'b0;
		modelCarry = 1'b0;
		committed  = 0;
		forever begin
			@(negedge clk);
			#(clkPeriod/4); // inputs moved at the falling edge, flops at the rising one
			if (!rst) begin
				checkFlags(flagZero, flagNeg, flagCarry, modelZero, modelNeg, modelCarry,
					"flags");
				predictResult(instr, modelRegs, modelZero, modelNeg, modelCarry,
					expRes, expZ, expN, expC, writes, hasResult);
				if (hasResult) begin
					checkWord(result, expRes, $sformatf("result of instr %h", instr));
				end
				if (instrValid) begin
					if (writes) begin
						modelRegs[instr[11:8]] = expRes; // dst field
					end
					modelZero  = expZ;
					modelNeg   = expN;
					modelCarry = expC;
					committed++;
				end
			end
		end
	end

	initial begin : stimulus
		instr_u                w;
		logic [31:0]           r;
		logic [addrWidth-1:0]  d;
		logic [addrWidth-1:0]  s;
		logic [addrWidth-1:0]  prevDst;
		logic [addrWidth-1:0]  nextDst;
		logic [immWidth-1:0]   imm;
		void'($urandom(randSeed));
		rst        = 1'b1;
		instrValid = 1'b0;
		instr      = encodeReg(NOP, '0, '0);
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		#(clkPeriod/4);
		checkFlags(flagZero, flagNeg, flagCarry, 1'b0, 1'b0, 1'b0, "flags after reset");

		// every register reads 0 after reset
		movSweep();

		// load, read back, reload the same value
		for (int x = 0; x < regCount; x++) begin
			imm = randImm();
			issue(encodeImm(LDI, addrWidth'(x), imm), 1'b1);
			issue(encodeReg(MOV, addrWidth'(x), addrWidth'(x)), 1'b1);
			issue(encodeImm(LDI, addrWidth'(x), imm), 1'b1);
			issue(encodeReg(MOV, addrWidth'(x), addrWidth'(x)), 1'b1);
		end

		// 16-bit boundary first
		issue(encodeImm(LDI, 4'd0, 8'hFF), 1'b1); // r0 = ffff
		issue(encodeImm(LDI, 4'd1, 8'h01), 1'b1); // r1 = 1
		issue(encodeReg(ADD, 4'd0, 4'd1), 1'b1);  // wraps to 0 with carry
		issue(encodeImm(LDI, 4'd2, 8'h00), 1'b1);
		issue(encodeReg(SUB, 4'd2, 4'd1), 1'b1);  // 0 - 1 borrows
		issue(encodeReg(CMP, 4'd1, 4'd1), 1'b1);  // equal, zero and no borrow
		for (int i = 0; i < numArith; i++) begin
			r = $urandom();
			d = randReg();
			s = randReg();
			case (r % 4)
				0: w = encodeReg(ADD, d, s);
				1: w = encodeReg(SUB, d, s);
				2: w = encodeImm(ADDI, d, randImm());
				default: w = encodeReg(CMP, d, s);
			endcase
			issue(w, 1'b1);
		end
		movSweep(); // CMP destinations untouched

		// logic and shifts
		for (int i = 0; i < numLogic; i++) begin
			r = $urandom();
			d = randReg();
			s = randReg();
			case (r % 6)
				0: w = encodeReg(AND, d, s);
				1: w = encodeReg(OR, d, s);
				2: w = encodeReg(XOR, d, s);
				3: w = encodeReg(SHL, d, s);
				4: w = encodeReg(SHR, d, s);
				default: w = encodeImm(LDI, d, randImm()); // keeps values from dying out
			endcase
			issue(w, 1'b1);
		end

		// strobe low, opcodes ADD to LDI with random fields
		for (int i = 0; i < numGated; i++) begin
			r = $urandom();
			w = {r[19:16] % 4'd10, r[11:0]};
			issue(w, 1'b0);
		end
		for (int i = 0; i < numNop; i++) begin
			issue(encodeReg(NOP, randReg(), randReg()), 1'b1);
		end
		movSweep();

		// each instruction reads what the one before wrote
		prevDst = randReg();
		issue(encodeImm(LDI, prevDst, randImm()), 1'b1);
		for (int i = 0; i < numChain; i++) begin
			r       = $urandom();
			nextDst = randReg();
			case (r % 4)
				0: w = encodeReg(ADD, nextDst, prevDst);
				1: w = encodeReg(SUB, nextDst, prevDst);
				2: w = encodeReg(XOR, nextDst, prevDst);
				default: begin
					w       = encodeImm(ADDI, prevDst, randImm());
					nextDst = prevDst;
				end
			endcase
			issue(w, 1'b1);
			prevDst = nextDst;
		end

		// let the compare process see the last flags
		issue(encodeReg(NOP, '0, '0), 1'b0);
		@(negedge clk);
		#(clkPeriod/2);
		$display("%0d instructions committed and checked", committed);
		$display("Simulation PASSED");
		$finish;
	end

	initial begin : watchdog
		#(watchdogTime);
		$display("timeout at %0t, the stimulus did not reach its end", $time);
		$display("Simulation FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

// ==== flist.f ====
coreDefs.sv
registerFile.sv
instrDecoder.sv
alu.sv
execCore.sv
execCore_tb.sv

// ==== runSim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f flist.f --top-module execCore_tb -o execCoreSim &&
./obj_dir/execCoreSim | tee /dev/stderr | grep -q "Simulation PASSED" &&
echo "execCore test run ok" ||
{ echo "execCore test run did not pass"; exit 1; }
